// ==== sim.f ====
+incdir+verilog
verilog/lane_pkg.sv
verilog/lane_regfile.sv
verilog/element_extract.sv
verilog/lane_alu.sv
verilog/writeback_stage.sv
verilog/vector_lane.sv
test/lane_tb.sv

// ==== test/lane_tb.sv ====
// Self-checking testbench for the vector lane, compiled from sim.f with lane_tb as top
`timescale 1ns/1ps
`include "lane_macros.svh"

module lane_tb import lane_pkg::*; ();

    // Issue cycles of all tests plus the drains between them
    localparam int SCHED_CYCLES = 260;
    localparam int TIMEOUT_CYCLES = 2 * SCHED_CYCLES + 100;

    typedef struct packed {
        logic  chk;
        word_t val;
    } exp_t;

    // One model write, applied at the DUT write-back edge
    typedef struct packed {
        int         due;
        vreg_addr_t addr;
        word_t      data;
        bwen_t      bwen;
        logic       vm;
        mask_addr_t maddr;
        logic       mwen;
        logic       mbit;
    } wb_t;

    logic                             clk_i;
    logic                             rst_i;
    sew_t                             vsew_i;
    logic       [`LANE_RD_PORTS-1:0] rd_en_i;
    vreg_addr_t [`LANE_RD_PORTS-1:0] rd_addr_i;
    el_idx_t    [`LANE_RD_PORTS-1:0] el_idx_i;
    logic       [`LANE_WR_PORTS-1:0] issue_valid_i;
    alu_op_t    [`LANE_WR_PORTS-1:0] alu_op_i;
    op2_sel_t   [`LANE_WR_PORTS-1:0] op2_sel_i;
    word_t      [`LANE_WR_PORTS-1:0] x_data_i;
    imm_t       [`LANE_WR_PORTS-1:0] imm_i;
    vreg_addr_t [`LANE_WR_PORTS-1:0] wr_addr_i;
    bwen_t      [`LANE_WR_PORTS-1:0] wr_bwen_i;
    wr_src_t    [`LANE_WR_PORTS-1:0] wr_src_i;
    word_t      [`LANE_WR_PORTS-1:0] load_data_i;
    logic       [`LANE_WR_PORTS-1:0] vm_i;
    mask_addr_t [`LANE_WR_PORTS-1:0] vmrf_addr_i;
    logic       [`LANE_WR_PORTS-1:0] vmrf_wen_i;
    word_t      [`LANE_WR_PORTS-1:0] alu_result_o;
    logic       [`LANE_WR_PORTS-1:0] alu_valid_o;

    // Reference model state
    word_t                       model_rf [`LANE_VRF_DEPTH];
    logic [`LANE_VMRF_DEPTH-1:0] model_mask;
    exp_t                        exp_q [`LANE_WR_PORTS][$];
    exp_t                        head [`LANE_WR_PORTS];
    wb_t                         pend [$];
    int                          cycle;

    vector_lane vector_lane_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic word_t width_mask();
        case (vsew_i)
            `LANE_SEW_8:  return word_t'(8'hff);
            `LANE_SEW_16: return word_t'(16'hffff);
            default:      return '1;
        endcase
    endfunction

    // Selected element of a word, zero-extended
    function automatic word_t pick_elem(input word_t w, input el_idx_t idx);
        case (vsew_i)
            `LANE_SEW_8:  return (w >> (8 * idx)) & 32'hff;
            `LANE_SEW_16: return (w >> (16 * idx[0])) & 32'hffff;
            default:      return w;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Stimulus tasks, called on a falling edge
    //////////////////////////////////////////////////
    task automatic set_load(input int s, input vreg_addr_t wa, input word_t data,
                            input bwen_t be, input logic masked, input mask_addr_t ma);
        issue_valid_i[s] = 1'b1;
        alu_op_i[s]      = `LANE_OP_ADD;
        op2_sel_i[s]     = `LANE_OP2_IMM;
        imm_i[s]         = '0;
        wr_addr_i[s]     = wa;
        wr_bwen_i[s]     = be;
        wr_src_i[s]      = `LANE_SRC_LOAD;
        load_data_i[s]   = data;
        vm_i[s]          = masked;
        vmrf_addr_i[s]   = ma;
        vmrf_wen_i[s]    = 1'b0;
        // Ports stay idle, so the ALU result is not checked
        exp_q[s].push_back('{1'b0, '0});
        pend.push_back('{cycle + 5, wa, data, be, masked, ma, 1'b0, 1'b0});
    endtask

    task automatic set_alu(input int s, input alu_op_t op, input op2_sel_t sel,
                           input word_t x, input vreg_addr_t ra, input vreg_addr_t rb,
                           input el_idx_t ia, input mask_addr_t ma, input logic mw);
        word_t a;
        word_t b;
        word_t res;
        logic  cmp;
        rd_en_i[2*s]     = 1'b1;
        rd_addr_i[2*s]   = ra;
        el_idx_i[2*s]    = ia;
        rd_en_i[2*s+1]   = 1'b1;
        rd_addr_i[2*s+1] = rb;
        el_idx_i[2*s+1]  = ia;
        issue_valid_i[s] = 1'b1;
        alu_op_i[s]      = op;
        op2_sel_i[s]     = sel;
        x_data_i[s]      = x;
        imm_i[s]         = imm_t'(x);
        wr_addr_i[s]     = '0;
        wr_bwen_i[s]     = '0;
        wr_src_i[s]      = `LANE_SRC_ALU;
        vm_i[s]          = 1'b0;
        vmrf_addr_i[s]   = ma;
        vmrf_wen_i[s]    = mw;
        a = pick_elem(model_rf[ra], ia) & width_mask();
        case (sel)
            `LANE_OP2_VEC:    b = pick_elem(model_rf[rb], ia);
            `LANE_OP2_SCALAR: b = x;
            default:          b = {27'd0, x[4:0]};
        endcase
        b = b & width_mask();
        case (op)
            `LANE_OP_ADD: res = a + b;
            `LANE_OP_SUB: res = a - b;
            `LANE_OP_AND: res = a & b;
            `LANE_OP_OR:  res = a | b;
            `LANE_OP_XOR: res = a ^ b;
            `LANE_OP_SLT: res = (a < b) ? 32'd1 : 32'd0;
            default:      res = (a == b) ? 32'd1 : 32'd0;
        endcase
        res = res & width_mask();
        cmp = (op == `LANE_OP_SLT || op == `LANE_OP_SEQ) && res[0];
        exp_q[s].push_back('{1'b1, res});
        pend.push_back('{cycle + 5, '0, res, 4'b0000, 1'b0, ma, mw, cmp});
    endtask

    task automatic next_cycle();
        @(negedge clk_i);
        issue_valid_i = '0;
        rd_en_i       = '0;
    endtask

    // Waits until every issued command has written back
    task automatic drain();
        next_cycle();
        while (pend.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    // Two words per cycle through ADD with immediate 0
    task automatic read_words(input int first, input int count);
        for (int i = 0; i < count; i += 2) begin
            set_alu(0, `LANE_OP_ADD, `LANE_OP2_IMM, '0, vreg_addr_t'(first + i), '0, '0,
                    '0, 1'b0);
            set_alu(1, `LANE_OP_ADD, `LANE_OP2_IMM, '0, vreg_addr_t'(first + i + 1), '0, '0,
                    '0, 1'b0);
            next_cycle();
        end
        drain();
    endtask

    //////////////////////////////////////////////////
    // Model write-back and cycle limit
    //////////////////////////////////////////////////
    always @(posedge clk_i) begin
        wb_t                         wb;
        bwen_t                       be;
        logic [`LANE_VMRF_DEPTH-1:0] mask_now;
        cycle++;
        if (cycle > TIMEOUT_CYCLES) begin
            fail_run($sformatf("Simulation timed out after %0d cycles", cycle));
        end else begin
            // Gating uses the mask bits from before this edge
            mask_now = model_mask;
            while (pend.size() != 0 && pend[0].due == cycle) begin
                wb = pend.pop_front();
                be = wb.bwen;
                if (wb.vm) begin
                    be = be & {`LANE_BYTES{mask_now[wb.maddr]}};
                end
                for (int b = 0; b < `LANE_BYTES; b++) begin
                    if (be[b]) begin
                        model_rf[wb.addr][8*b +: 8] = wb.data[8*b +: 8];
                    end
                end
                if (wb.mwen) begin
                    model_mask[wb.maddr] = wb.mbit;
                end
            end
        end
    end

    // Expected result moves to the head while the DUT valid is up
    always @(negedge clk_i) begin
        for (int s = 0; s < `LANE_WR_PORTS; s++) begin
            if (rst_i && alu_valid_o[s]) begin
                if (exp_q[s].size() == 0) begin
                    fail_run($sformatf("ERROR at %0t: slot %0d gave a result with no command",
                                       $time, s));
                end else begin
                    head[s] = exp_q[s].pop_front();
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    for (genvar j = 0; j < `LANE_WR_PORTS; j++) begin : g_check
        a_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
            alu_valid_o[j] == $past(issue_valid_i[j], `LANE_WB_DELAY))
            else fail_run($sformatf("ERROR at %0t: slot %0d valid not %0d edges after issue",
                                    $time, j, `LANE_WB_DELAY));
        a_result: assert property (@(posedge clk_i) disable iff (!rst_i)
            alu_valid_o[j] && head[j].chk |-> alu_result_o[j] == head[j].val)
            else fail_run($sformatf("ERROR at %0t: slot %0d result %h, expected %h",
                                    $time, j, $sampled(alu_result_o[j]), head[j].val));
    end

    initial begin
        vreg_addr_t ra0;
        vreg_addr_t ra1;
        vreg_addr_t rb0;
        vreg_addr_t rb1;
        op2_sel_t   sel0;
        op2_sel_t   sel1;
        word_t      x0;
        void'($urandom(55));
        cycle         = 0;
        model_mask    = '0;
        rst_i         = 1'b0;
        vsew_i        = `LANE_SEW_32;
        rd_en_i       = '0;
        rd_addr_i     = '0;
        el_idx_i      = '0;
        issue_valid_i = '0;
        alu_op_i      = '0;
        op2_sel_i     = '0;
        x_data_i      = '0;
        imm_i         = '0;
        wr_addr_i     = '0;
        wr_bwen_i     = '0;
        wr_src_i      = '0;
        load_data_i   = '0;
        vm_i          = '0;
        vmrf_addr_i   = '0;
        vmrf_wen_i    = '0;
        repeat (8) @(negedge clk_i);
        rst_i = 1'b1;
        // Idle after reset, no valid may appear
        repeat (4) next_cycle();

        // Fill the whole register file, then read it back
        for (int i = 0; i < 32; i++) begin
            set_load(0, vreg_addr_t'(2 * i), $urandom(), '1, 1'b0, '0);
            set_load(1, vreg_addr_t'(2 * i + 1), $urandom(), '1, 1'b0, '0);
            next_cycle();
        end
        drain();
        read_words(0, `LANE_VRF_DEPTH);

        // Every byte and halfword index
        for (int w = 0; w < 2; w++) begin
            vsew_i = (w == 0) ? `LANE_SEW_8 : `LANE_SEW_16;
            for (int i = 0; i < 8; i++) begin
                set_alu(0, `LANE_OP_ADD, `LANE_OP2_IMM, '0, vreg_addr_t'(i), '0,
                        el_idx_t'(i), '0, 1'b0);
                set_alu(1, `LANE_OP_ADD, `LANE_OP2_IMM, '0, vreg_addr_t'(i + 8), '0,
                        el_idx_t'(i + 1), '0, 1'b0);
                next_cycle();
            end
            drain();
        end
        vsew_i = `LANE_SEW_32;

        // All operations, scalar on slot 0 and immediate on slot 1
        for (int op = 0; op < 7; op++) begin
            for (int n = 0; n < 4; n++) begin
                ra0 = vreg_addr_t'($urandom());
                ra1 = vreg_addr_t'($urandom());
                rb0 = vreg_addr_t'($urandom());
                rb1 = vreg_addr_t'($urandom());
                x0  = (n == 0) ? model_rf[ra0] : word_t'($urandom());
                // Last pass takes operand 2 from the odd read port instead
                sel0 = (n == 3) ? `LANE_OP2_VEC : `LANE_OP2_SCALAR;
                sel1 = (n == 3) ? `LANE_OP2_VEC : `LANE_OP2_IMM;
                set_alu(0, alu_op_t'(op), sel0, x0, ra0, rb0, '0, '0, 1'b0);
                set_alu(1, alu_op_t'(op), sel1, $urandom(), ra1, rb1, '0, '0, 1'b0);
                next_cycle();
            end
        end
        drain();

        // Random byte enables, back to back on both slots
        for (int i = 0; i < 16; i++) begin
            set_load(0, vreg_addr_t'(i), $urandom(), bwen_t'($urandom()), 1'b0, '0);
            set_load(1, vreg_addr_t'(i + 16), $urandom(), bwen_t'($urandom()), 1'b0, '0);
            next_cycle();
        end
        drain();
        read_words(0, 32);

        // Mask bits from SLT, then loads gated by them
        for (int i = 0; i < 16; i++) begin
            set_alu(0, `LANE_OP_SLT, `LANE_OP2_SCALAR, 32'h8000_0000, vreg_addr_t'(i), '0,
                    '0, mask_addr_t'(i), 1'b1);
            set_alu(1, `LANE_OP_SLT, `LANE_OP2_SCALAR, 32'h8000_0000, vreg_addr_t'(i + 16),
                    '0, '0, mask_addr_t'(i + 16), 1'b1);
            next_cycle();
        end
        drain();
        for (int i = 0; i < 16; i++) begin
            set_load(0, vreg_addr_t'(i), $urandom(), '1, 1'b1, mask_addr_t'(i));
            set_load(1, vreg_addr_t'(i + 16), $urandom(), '1, 1'b1, mask_addr_t'(i + 16));
            next_cycle();
        end
        drain();
        read_words(0, 32);

        if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            fail_run("Run ended with ALU results still outstanding");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog/element_extract.sv ====
// Per read port element selector, picks a byte, halfword or word by SEW and index
`timescale 1ns/1ps
`include "lane_macros.svh"

module element_extract import lane_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  sew_t    vsew_i,
    input  el_idx_t el_idx_i,
    input  word_t   rd_data_i,
    output word_t   elem_o
);

    el_idx_t idx_d1;
    el_idx_t idx_d2;
    word_t   elem_next;

    // Index follows the two-cycle register file read
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            idx_d1 <= '0;
            idx_d2 <= '0;
        end else begin
            idx_d1 <= el_idx_i;
            idx_d2 <= idx_d1;
        end
    end

    // Zero-extended element
    always_comb begin
        case (vsew_i)
            `LANE_SEW_8:  elem_next = word_t'(rd_data_i[{idx_d2, 3'b000} +: 8]);
            `LANE_SEW_16: elem_next = word_t'(rd_data_i[{idx_d2[0], 4'b0000} +: 16]);
            `LANE_SEW_32: elem_next = rd_data_i;
            default:      elem_next = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        elem_o <= elem_next;
    end

endmodule

// ==== verilog/lane_alu.sv ====
// One slot ALU, aligns the command with its operands and registers result, mask bit and valid
`timescale 1ns/1ps
`include "lane_macros.svh"

module lane_alu import lane_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  sew_t     vsew_i,
    input  logic     issue_valid_i,
    input  alu_op_t  alu_op_i,
    input  op2_sel_t op2_sel_i,
    input  word_t    x_data_i,
    input  imm_t     imm_i,
    input  word_t    op1_i,
    input  word_t    op2_vec_i,
    output word_t    result_o,
    output logic     mask_o,
    output logic     valid_o
);

    // Operands arrive one stage before the result
    localparam int CMD_STAGES = `LANE_WB_DELAY - 1;
    localparam int LAST = CMD_STAGES - 1;

    logic     vld_q  [CMD_STAGES];
    alu_op_t  op_q   [CMD_STAGES];
    op2_sel_t sel_q  [CMD_STAGES];
    word_t    x_q    [CMD_STAGES];
    imm_t     imm_q  [CMD_STAGES];

    word_t wmask;
    word_t op2;
    word_t a;
    word_t b;
    word_t res;
    logic  cmp;

    //////////////////////////////////////////////////
    // Command delay line
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < CMD_STAGES; i++) begin
                vld_q[i] <= 1'b0;
                op_q[i]  <= '0;
                sel_q[i] <= '0;
                x_q[i]   <= '0;
                imm_q[i] <= '0;
            end
        end else begin
            vld_q[0] <= issue_valid_i;
            op_q[0]  <= alu_op_i;
            sel_q[0] <= op2_sel_i;
            x_q[0]   <= x_data_i;
            imm_q[0] <= imm_i;
            for (int i = 1; i < CMD_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
                op_q[i]  <= op_q[i-1];
                sel_q[i] <= sel_q[i-1];
                x_q[i]   <= x_q[i-1];
                imm_q[i] <= imm_q[i-1];
            end
        end
    end

    // Operands are cut to the element width before use
    always_comb begin
        case (vsew_i)
            `LANE_SEW_8:  wmask = word_t'(8'hff);
            `LANE_SEW_16: wmask = word_t'(16'hffff);
            `LANE_SEW_32: wmask = '1;
            default:      wmask = '0;
        endcase
        case (sel_q[LAST])
            `LANE_OP2_VEC:    op2 = op2_vec_i;
            `LANE_OP2_SCALAR: op2 = x_q[LAST];
            `LANE_OP2_IMM:    op2 = word_t'(imm_q[LAST]);
            default:          op2 = '0;
        endcase
        a   = op1_i & wmask;
        b   = op2 & wmask;
        cmp = 1'b0;
        case (op_q[LAST])
            `LANE_OP_ADD: res = a + b;
            `LANE_OP_SUB: res = a - b;
            `LANE_OP_AND: res = a & b;
            `LANE_OP_OR:  res = a | b;
            `LANE_OP_XOR: res = a ^ b;
            `LANE_OP_SLT: begin
                cmp = (a < b);
                res = word_t'(cmp);
            end
            `LANE_OP_SEQ: begin
                cmp = (a == b);
                res = word_t'(cmp);
            end
            default:      res = '0;
        endcase
        res = res & wmask;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= vld_q[LAST];
        end
        result_o <= res;
        mask_o   <= cmp;
    end

    // Unused SEW or op2 codes never issue
    a_legal_cmd: assert property (@(posedge clk_i) disable iff (!rst_i)
        issue_valid_i |-> (vsew_i != 2'd3 && op2_sel_i != 2'd3))
        else $error("command issued with an unused SEW or op2 code");

endmodule

// ==== verilog/lane_macros.svh ====
// Lane sizes, pipeline depth and operation codes, included by the package, RTL and testbench
`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

// Port counts and storage sizes
`define LANE_RD_PORTS    4
`define LANE_WR_PORTS    2
`define LANE_WORD_W      32
`define LANE_BYTES       4
`define LANE_VRF_DEPTH   64
`define LANE_VMRF_DEPTH  32

// Edges from issue to ALU result
`define LANE_WB_DELAY    4

// ALU operations
`define LANE_OP_ADD      3'd0
`define LANE_OP_SUB      3'd1
`define LANE_OP_AND      3'd2
`define LANE_OP_OR       3'd3
`define LANE_OP_XOR      3'd4
`define LANE_OP_SLT      3'd5
`define LANE_OP_SEQ      3'd6

// Operand 2 sources
`define LANE_OP2_VEC     2'd0
`define LANE_OP2_SCALAR  2'd1
`define LANE_OP2_IMM     2'd2

// Element widths, code 3 is unused
`define LANE_SEW_8       2'd0
`define LANE_SEW_16      2'd1
`define LANE_SEW_32      2'd2

// Write data sources
`define LANE_SRC_ALU     1'b0
`define LANE_SRC_LOAD    1'b1

`endif

// ==== verilog/lane_pkg.sv ====
// Vector typedefs for the lane widths, imported by every RTL module and the testbench
`include "lane_macros.svh"

package lane_pkg;

    // One register word and its byte enables
    typedef logic [`LANE_WORD_W-1:0] word_t;
    typedef logic [`LANE_BYTES-1:0]  bwen_t;

    // Addresses into the register file and the mask file
    typedef logic [$clog2(`LANE_VRF_DEPTH)-1:0]  vreg_addr_t;
    typedef logic [$clog2(`LANE_VMRF_DEPTH)-1:0] mask_addr_t;

    // Element selection
    typedef logic [1:0] sew_t;
    typedef logic [1:0] el_idx_t;

    // Slot command fields
    typedef logic [2:0] alu_op_t;
    typedef logic [1:0] op2_sel_t;
    typedef logic [4:0] imm_t;
    typedef logic       wr_src_t;

endpackage

// ==== verilog/lane_regfile.sv ====
// Byte-enabled lane register file, two-cycle read per port, one write per slot
`timescale 1ns/1ps
`include "lane_macros.svh"

module lane_regfile import lane_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic       [`LANE_RD_PORTS-1:0] rd_en_i,
    input  vreg_addr_t [`LANE_RD_PORTS-1:0] rd_addr_i,
    input  logic       [`LANE_WR_PORTS-1:0] wr_en_i,
    input  vreg_addr_t [`LANE_WR_PORTS-1:0] wr_addr_i,
    input  word_t      [`LANE_WR_PORTS-1:0] wr_data_i,
    input  bwen_t      [`LANE_WR_PORTS-1:0] wr_bwen_i,
    output word_t      [`LANE_RD_PORTS-1:0] rd_data_o
);

    word_t                     mem [`LANE_VRF_DEPTH];
    word_t [`LANE_RD_PORTS-1:0] rd_word;
    word_t [`LANE_RD_PORTS-1:0] rd_q;
    logic  [`LANE_RD_PORTS-1:0] rd_en_q;

    // Array read, bytes written on the same edge are returned
    always_comb begin
        for (int p = 0; p < `LANE_RD_PORTS; p++) begin
            rd_word[p] = mem[rd_addr_i[p]];
            for (int s = 0; s < `LANE_WR_PORTS; s++) begin
                for (int b = 0; b < `LANE_BYTES; b++) begin
                    if (wr_en_i[s] && wr_bwen_i[s][b] && wr_addr_i[s] == rd_addr_i[p]) begin
                        rd_word[p][8*b +: 8] = wr_data_i[s][8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int s = 0; s < `LANE_WR_PORTS; s++) begin
            for (int b = 0; b < `LANE_BYTES; b++) begin
                if (wr_en_i[s] && wr_bwen_i[s][b]) begin
                    mem[wr_addr_i[s]][8*b +: 8] <= wr_data_i[s][8*b +: 8];
                end
            end
        end
    end

    // Read stage then output register, both hold when idle
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rd_en_q <= '0;
        end else begin
            rd_en_q <= rd_en_i;
        end
        for (int p = 0; p < `LANE_RD_PORTS; p++) begin
            if (rd_en_i[p]) begin
                rd_q[p] <= rd_word[p];
            end
            if (rd_en_q[p]) begin
                rd_data_o[p] <= rd_q[p];
            end
        end
    end

    // Slots must not write the same byte on one edge
    a_no_byte_clash: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(wr_en_i[0] && wr_en_i[1] && wr_addr_i[0] == wr_addr_i[1] &&
          |(wr_bwen_i[0] & wr_bwen_i[1])))
        else $error("both slots write the same byte of word %0d", wr_addr_i[0]);

endmodule

// ==== verilog/vector_lane.sv ====
// Top of one vector lane, connects the register file, extractors, ALU slots and write-back
`timescale 1ns/1ps
`include "lane_macros.svh"

module vector_lane import lane_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  sew_t                             vsew_i,
    // Read ports
    input  logic       [`LANE_RD_PORTS-1:0] rd_en_i,
    input  vreg_addr_t [`LANE_RD_PORTS-1:0] rd_addr_i,
    input  el_idx_t    [`LANE_RD_PORTS-1:0] el_idx_i,
    // Slot commands
    input  logic       [`LANE_WR_PORTS-1:0] issue_valid_i,
    input  alu_op_t    [`LANE_WR_PORTS-1:0] alu_op_i,
    input  op2_sel_t   [`LANE_WR_PORTS-1:0] op2_sel_i,
    input  word_t      [`LANE_WR_PORTS-1:0] x_data_i,
    input  imm_t       [`LANE_WR_PORTS-1:0] imm_i,
    input  vreg_addr_t [`LANE_WR_PORTS-1:0] wr_addr_i,
    input  bwen_t      [`LANE_WR_PORTS-1:0] wr_bwen_i,
    input  wr_src_t    [`LANE_WR_PORTS-1:0] wr_src_i,
    input  word_t      [`LANE_WR_PORTS-1:0] load_data_i,
    input  logic       [`LANE_WR_PORTS-1:0] vm_i,
    input  mask_addr_t [`LANE_WR_PORTS-1:0] vmrf_addr_i,
    input  logic       [`LANE_WR_PORTS-1:0] vmrf_wen_i,
    // Slot results
    output word_t      [`LANE_WR_PORTS-1:0] alu_result_o,
    output logic       [`LANE_WR_PORTS-1:0] alu_valid_o
);

    word_t      [`LANE_RD_PORTS-1:0] rd_data;
    word_t      [`LANE_RD_PORTS-1:0] elem;
    logic       [`LANE_WR_PORTS-1:0] alu_mask;
    logic       [`LANE_WR_PORTS-1:0] rf_wr_en;
    vreg_addr_t [`LANE_WR_PORTS-1:0] rf_wr_addr;
    word_t      [`LANE_WR_PORTS-1:0] rf_wr_data;
    bwen_t      [`LANE_WR_PORTS-1:0] rf_wr_bwen;

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////
    lane_regfile lane_regfile_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_en_i    (rd_en_i),
        .rd_addr_i  (rd_addr_i),
        .wr_en_i    (rf_wr_en),
        .wr_addr_i  (rf_wr_addr),
        .wr_data_i  (rf_wr_data),
        .wr_bwen_i  (rf_wr_bwen),
        .rd_data_o  (rd_data)
    );

    // One extractor per read port
    for (genvar p = 0; p < `LANE_RD_PORTS; p++) begin : g_extract
        element_extract element_extract_i (
            .clk_i      (clk_i),
            .rst_i      (rst_i),
            .vsew_i     (vsew_i),
            .el_idx_i   (el_idx_i[p]),
            .rd_data_i  (rd_data[p]),
            .elem_o     (elem[p])
        );
    end

    //////////////////////////////////////////////////
    // ALU slots, slot j reads ports 2j and 2j+1
    //////////////////////////////////////////////////
    for (genvar j = 0; j < `LANE_WR_PORTS; j++) begin : g_slot
        lane_alu lane_alu_i (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .vsew_i         (vsew_i),
            .issue_valid_i  (issue_valid_i[j]),
            .alu_op_i       (alu_op_i[j]),
            .op2_sel_i      (op2_sel_i[j]),
            .x_data_i       (x_data_i[j]),
            .imm_i          (imm_i[j]),
            .op1_i          (elem[2*j]),
            .op2_vec_i      (elem[2*j+1]),
            .result_o       (alu_result_o[j]),
            .mask_o         (alu_mask[j]),
            .valid_o        (alu_valid_o[j])
        );
    end

    // Write-back and mask file
    writeback_stage writeback_stage_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .wr_addr_i      (wr_addr_i),
        .wr_bwen_i      (wr_bwen_i),
        .wr_src_i       (wr_src_i),
        .load_data_i    (load_data_i),
        .vm_i           (vm_i),
        .vmrf_addr_i    (vmrf_addr_i),
        .vmrf_wen_i     (vmrf_wen_i),
        .alu_result_i   (alu_result_o),
        .alu_mask_i     (alu_mask),
        .alu_valid_i    (alu_valid_o),
        .rf_wr_en_o     (rf_wr_en),
        .rf_wr_addr_o   (rf_wr_addr),
        .rf_wr_data_o   (rf_wr_data),
        .rf_wr_bwen_o   (rf_wr_bwen)
    );

endmodule

// ==== verilog/writeback_stage.sv ====
// Slot write-back, delays write controls to the ALU result and owns the mask file
`timescale 1ns/1ps
`include "lane_macros.svh"

module writeback_stage import lane_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic       [`LANE_WR_PORTS-1:0] issue_valid_i,
    input  vreg_addr_t [`LANE_WR_PORTS-1:0] wr_addr_i,
    input  bwen_t      [`LANE_WR_PORTS-1:0] wr_bwen_i,
    input  wr_src_t    [`LANE_WR_PORTS-1:0] wr_src_i,
    input  word_t      [`LANE_WR_PORTS-1:0] load_data_i,
    input  logic       [`LANE_WR_PORTS-1:0] vm_i,
    input  mask_addr_t [`LANE_WR_PORTS-1:0] vmrf_addr_i,
    input  logic       [`LANE_WR_PORTS-1:0] vmrf_wen_i,
    input  word_t      [`LANE_WR_PORTS-1:0] alu_result_i,
    input  logic       [`LANE_WR_PORTS-1:0] alu_mask_i,
    input  logic       [`LANE_WR_PORTS-1:0] alu_valid_i,
    output logic       [`LANE_WR_PORTS-1:0] rf_wr_en_o,
    output vreg_addr_t [`LANE_WR_PORTS-1:0] rf_wr_addr_o,
    output word_t      [`LANE_WR_PORTS-1:0] rf_wr_data_o,
    output bwen_t      [`LANE_WR_PORTS-1:0] rf_wr_bwen_o
);

    localparam int LAST = `LANE_WB_DELAY - 1;

    logic       [`LANE_WR_PORTS-1:0] vld_q   [`LANE_WB_DELAY];
    vreg_addr_t [`LANE_WR_PORTS-1:0] addr_q  [`LANE_WB_DELAY];
    bwen_t      [`LANE_WR_PORTS-1:0] bwen_q  [`LANE_WB_DELAY];
    wr_src_t    [`LANE_WR_PORTS-1:0] src_q   [`LANE_WB_DELAY];
    word_t      [`LANE_WR_PORTS-1:0] load_q  [`LANE_WB_DELAY];
    logic       [`LANE_WR_PORTS-1:0] vm_q    [`LANE_WB_DELAY];
    mask_addr_t [`LANE_WR_PORTS-1:0] maddr_q [`LANE_WB_DELAY];
    logic       [`LANE_WR_PORTS-1:0] mwen_q  [`LANE_WB_DELAY];

    logic [`LANE_VMRF_DEPTH-1:0] vmrf_q;

    //////////////////////////////////////////////////
    // Write control delay line
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `LANE_WB_DELAY; i++) begin
                vld_q[i]   <= '0;
                addr_q[i]  <= '0;
                bwen_q[i]  <= '0;
                src_q[i]   <= '0;
                load_q[i]  <= '0;
                vm_q[i]    <= '0;
                maddr_q[i] <= '0;
                mwen_q[i]  <= '0;
            end
        end else begin
            vld_q[0]   <= issue_valid_i;
            addr_q[0]  <= wr_addr_i;
            bwen_q[0]  <= wr_bwen_i;
            src_q[0]   <= wr_src_i;
            load_q[0]  <= load_data_i;
            vm_q[0]    <= vm_i;
            maddr_q[0] <= vmrf_addr_i;
            mwen_q[0]  <= vmrf_wen_i;
            for (int i = 1; i < `LANE_WB_DELAY; i++) begin
                vld_q[i]   <= vld_q[i-1];
                addr_q[i]  <= addr_q[i-1];
                bwen_q[i]  <= bwen_q[i-1];
                src_q[i]   <= src_q[i-1];
                load_q[i]  <= load_q[i-1];
                vm_q[i]    <= vm_q[i-1];
                maddr_q[i] <= maddr_q[i-1];
                mwen_q[i]  <= mwen_q[i-1];
            end
        end
    end

    // Mask file, slot 1 is written last and wins
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            vmrf_q <= '0;
        end else begin
            for (int s = 0; s < `LANE_WR_PORTS; s++) begin
                if (vld_q[LAST][s] && mwen_q[LAST][s]) begin
                    vmrf_q[maddr_q[LAST][s]] <= alu_mask_i[s];
                end
            end
        end
    end

    // Data select and masked byte enables
    always_comb begin
        for (int s = 0; s < `LANE_WR_PORTS; s++) begin
            rf_wr_en_o[s]   = vld_q[LAST][s];
            rf_wr_addr_o[s] = addr_q[LAST][s];
            rf_wr_data_o[s] = (src_q[LAST][s] == `LANE_SRC_LOAD) ? load_q[LAST][s]
                                                                  : alu_result_i[s];
            rf_wr_bwen_o[s] = bwen_q[LAST][s];
            if (vm_q[LAST][s]) begin
                rf_wr_bwen_o[s] = bwen_q[LAST][s] & {`LANE_BYTES{vmrf_q[maddr_q[LAST][s]]}};
            end
        end
    end

    // The delay line must stay aligned with the ALU valid
    a_valid_align: assert property (@(posedge clk_i) disable iff (!rst_i)
        vld_q[LAST] == alu_valid_i)
        else $error("write-back valid out of step with ALU valid");

endmodule
